/* verilog/fpPipePkg.sv */
package fpPipePkg;

	localparam int stageCount = 3;		// Register slices in the chain
	localparam int latency = stageCount;	// Accept to output, no stalls

	// Operand and result classes
	typedef enum logic [2:0] {
		clsZero,		// Zero or subnormal
		clsNormal,
		clsInf,
		clsNan,
		clsInvalid		// Inf times zero
	} opClass;

endpackage

/* verilog/fpFormatPkg.sv */
package fpFormatPkg;

	// Binary16 field layout
	localparam int expWidth = 5;
	localparam int manWidth = 10;
	localparam int wordWidth = 1 + expWidth + manWidth;
	localparam int bias = 15;

	localparam int sigWidth = manWidth + 1;			// Hidden one included
	localparam int prodWidth = 2 * sigWidth;		// Full significand product
	localparam int expSumWidth = expWidth + 2;		// Room for sign and carry

	localparam logic [expWidth-1:0] expAllOnes = '1;	// Inf and NaN exponent
	localparam logic [wordWidth-1:0] qNan = 16'h7E00;	// Canonical quiet NaN

	// Stage 1 to stage 2
	typedef struct packed {
		logic signA;
		logic signB;
		logic [expWidth-1:0] expA;
		logic [expWidth-1:0] expB;
		logic [prodWidth-1:0] prod;
		fpPipePkg::opClass cls;
	} prepPayload;

	// Stage 2 to stage 3
	typedef struct packed {
		logic sign;
		logic signed [expSumWidth-1:0] exp;		// Biased result exponent, may leave range
		logic [manWidth-1:0] frac;
		logic guard;
		logic sticky;
		fpPipePkg::opClass cls;
	} execPayload;

	// Final word
	typedef struct packed {
		logic [wordWidth-1:0] result;
	} resPayload;

endpackage

/* verilog/fpPipeStage.sv */
`timescale 1ns/100ps

// Single-entry register slice with valid/ready on both sides
module fpPipeStage #(
	parameter type payloadType = logic
) (
	input logic clk,
	input logic rstN,

	input logic upValid,
	output logic upReady,
	input payloadType upData,

	output logic downValid,
	input logic downReady,
	output payloadType downData
);

	// Free when empty or being drained this cycle
	assign upReady = ~downValid | downReady;

	// Occupancy flag
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			downValid <= 1'b0;
		end else if (upReady) begin
			downValid <= upValid;	// Refill or go empty
		end
	end

	// Payload register
	always_ff @(posedge clk) begin
		if (upValid && upReady) begin
			downData <= upData;	// Load on transfer only
		end
		// Holds under stall
	end

endmodule

/* verilog/fpMultPrepare.sv */
`timescale 1ns/100ps

// Stage 1 logic
// Splits fields, classifies and multiplies significands
module fpMultPrepare (
	input logic [15:0] a,
	input logic [15:0] b,
	output fpFormatPkg::prepPayload prep
);

	import fpFormatPkg::*;
	import fpPipePkg::*;

	logic [expWidth-1:0] expA;
	logic [expWidth-1:0] expB;
	logic [manWidth-1:0] manA;
	logic [manWidth-1:0] manB;
	logic [sigWidth-1:0] sigA;
	logic [sigWidth-1:0] sigB;
	opClass clsA;
	opClass clsB;
	opClass cls;

	// Per-operand class, exponent 0 taken as zero
	function automatic opClass classify(
		input logic [expWidth-1:0] e,
		input logic [manWidth-1:0] m
	);
		opClass c;
		if (e == expAllOnes) begin
			c = (m != '0) ? clsNan : clsInf;
		end else if (e == '0) begin
			c = clsZero;			// Subnormals too
		end else begin
			c = clsNormal;
		end
		return c;
	endfunction

	assign expA = a[wordWidth-2 -: expWidth];
	assign expB = b[wordWidth-2 -: expWidth];
	assign manA = a[manWidth-1:0];
	assign manB = b[manWidth-1:0];

	assign sigA = {|expA, manA};		// Hidden one
	assign sigB = {|expB, manB};

	assign clsA = classify(expA, manA);
	assign clsB = classify(expB, manB);

	// Merge to one result class
	always_comb begin
		if (clsA == clsNan || clsB == clsNan) begin
			cls = clsNan;
		end else if ((clsA == clsInf && clsB == clsZero) ||
				(clsA == clsZero && clsB == clsInf)) begin
			cls = clsInvalid;		// Inf times zero
		end else if (clsA == clsInf || clsB == clsInf) begin
			cls = clsInf;
		end else if (clsA == clsZero || clsB == clsZero) begin
			cls = clsZero;
		end else begin
			cls = clsNormal;
		end
	end

	always_comb begin
		prep.signA = a[wordWidth-1];
		prep.signB = b[wordWidth-1];
		prep.expA = expA;
		prep.expB = expB;
		prep.prod = {{sigWidth{1'b0}}, sigA} * {{sigWidth{1'b0}}, sigB};	// 11x11 to 22
		prep.cls = cls;
	end

endmodule

/* verilog/fpMultExecute.sv */
`timescale 1ns/100ps

// Stage 2 logic
// Sign, exponent sum and normalization of the product
module fpMultExecute (
	input fpFormatPkg::prepPayload prep,
	output fpFormatPkg::execPayload exec
);

	import fpFormatPkg::*;

	logic carry;
	logic [expSumWidth-1:0] expSum;

	// Product in [2,4) when top bit set
	assign carry = prep.prod[prodWidth-1];

	// Exponents add, bias comes off once
	assign expSum = expSumWidth'(prep.expA) + expSumWidth'(prep.expB)
			+ expSumWidth'(carry) - expSumWidth'(bias);

	always_comb begin
		exec.sign = prep.signA ^ prep.signB;	// Equal signs give positive
		exec.exp = $signed(expSum);
		if (carry) begin
			exec.frac = prep.prod[prodWidth-2 -: manWidth];	// Bits 20..11
			exec.guard = prep.prod[manWidth];
			exec.sticky = |prep.prod[manWidth-1:0];
		end else begin
			exec.frac = prep.prod[prodWidth-3 -: manWidth];	// Bits 19..10
			exec.guard = prep.prod[manWidth-1];
			exec.sticky = |prep.prod[manWidth-2:0];
		end
		exec.cls = prep.cls;			// Class rides along
	end

endmodule

/* verilog/fpMultRound.sv */
`timescale 1ns/100ps

// Stage 3 logic
// Round to nearest even, range checks, specials and packing
module fpMultRound (
	input fpFormatPkg::execPayload exec,
	output fpFormatPkg::resPayload res
);

	import fpFormatPkg::*;
	import fpPipePkg::*;

	localparam logic signed [expSumWidth-1:0] expLimit = $signed({2'b00, expAllOnes});	// 31

	logic roundUp;
	logic [manWidth:0] fracInc;
	logic signed [expSumWidth-1:0] expRnd;
	logic overflow;
	logic underflow;
	logic [wordWidth-1:0] numeric;
	logic [wordWidth-1:0] signedInf;
	logic [wordWidth-1:0] signedZero;

	// Ties go to even
	assign roundUp = exec.guard & (exec.sticky | exec.frac[0]);

	assign fracInc = {1'b0, exec.frac} + {{manWidth{1'b0}}, roundUp};

	// All-ones fraction rounding up bumps the exponent
	assign expRnd = exec.exp + $signed({{(expSumWidth-1){1'b0}}, fracInc[manWidth]});

	assign overflow = expRnd >= expLimit;
	assign underflow = expRnd <= $signed({expSumWidth{1'b0}});	// No subnormal output

	assign signedInf = {exec.sign, expAllOnes, {manWidth{1'b0}}};
	assign signedZero = {exec.sign, {(wordWidth-1){1'b0}}};

	// Numeric path
	always_comb begin
		if (overflow) begin
			numeric = signedInf;			// Saturate
		end else if (underflow) begin
			numeric = signedZero;			// Flush
		end else begin
			numeric = {exec.sign, expRnd[expWidth-1:0], fracInc[manWidth-1:0]};
		end
	end

	// Class overrides the numeric result
	always_comb begin
		case (exec.cls)
			clsNan,
			clsInvalid: res.result = qNan;
			clsInf: res.result = signedInf;
			clsZero: res.result = signedZero;
			default: res.result = numeric;
		endcase
	end

endmodule

/* verilog/fpMultiplier.sv */
`timescale 1ns/100ps

// Three-stage binary16 multiplier
// Prepare, slice 1, execute, slice 2, round, slice 3
module fpMultiplier (
	input logic clk,
	input logic rstN,

	input logic inValid,
	output logic inReady,
	input logic [15:0] a,
	input logic [15:0] b,

	output logic outValid,
	input logic outReady,
	output logic [15:0] product
);

	import fpFormatPkg::*;

	prepPayload prepComb;		// Stage 1 logic out
	prepPayload prepReg;		// Slice 1 out
	execPayload execComb;
	execPayload execReg;
	resPayload resComb;
	resPayload resReg;

	logic slice1Valid;		// Slice 1 full
	logic slice1Ready;
	logic slice2Valid;		// Slice 2 full
	logic slice2Ready;

	fpMultPrepare prepare_i (
		.a(a),
		.b(b),
		.prep(prepComb)
	);

	fpPipeStage #(.payloadType(prepPayload)) slice1_i (
		.clk(clk),
		.rstN(rstN),
		.upValid(inValid),
		.upReady(inReady),
		.upData(prepComb),
		.downValid(slice1Valid),
		.downReady(slice1Ready),
		.downData(prepReg)
	);

	fpMultExecute execute_i (
		.prep(prepReg),
		.exec(execComb)
	);

	fpPipeStage #(.payloadType(execPayload)) slice2_i (
		.clk(clk),
		.rstN(rstN),
		.upValid(slice1Valid),
		.upReady(slice1Ready),
		.upData(execComb),
		.downValid(slice2Valid),
		.downReady(slice2Ready),
		.downData(execReg)
	);

	fpMultRound round_i (
		.exec(execReg),
		.res(resComb)
	);

	// Output slice drives the ports
	fpPipeStage #(.payloadType(resPayload)) slice3_i (
		.clk(clk),
		.rstN(rstN),
		.upValid(slice2Valid),
		.upReady(slice2Ready),
		.upData(resComb),
		.downValid(outValid),
		.downReady(outReady),
		.downData(resReg)
	);

	assign product = resReg.result;

endmodule

/* testbench/fpMultiplier_props.sv */
`timescale 1ns/100ps

// Handshake properties on the multiplier top level
module fpMultiplier_props (
	input logic clk,
	input logic rstN,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input logic [15:0] product,
	input logic slice1Valid,
	input logic slice2Valid
);

	import fpPipePkg::*;

	int failCount = 0;		// Failed assertion count

	// Output slice stays empty under reset
	resetEmpty: assert property (@(posedge clk) !rstN |-> !outValid)
		else begin
			failCount++;
			$error("outValid high while reset is asserted");
		end

	// Stalled output holds
	stallHold: assert property (@(posedge clk) disable iff (!rstN)
			outValid && !outReady |=> outValid && $stable(product))
		else begin
			failCount++;
			$error("outValid or product changed during a stall");
		end

	// Back-pressure only with every slice full
	readyLowFull: assert property (@(posedge clk) disable iff (!rstN)
			!inReady |-> $countones({slice1Valid, slice2Valid, outValid}) == stageCount)
		else begin
			failCount++;
			$error("inReady low with fewer than three items in flight");
		end

	// Full chain under stall refuses input
	fullRefuses: assert property (@(posedge clk) disable iff (!rstN)
			slice1Valid && slice2Valid && outValid && !outReady |-> !inReady)
		else begin
			failCount++;
			$error("inReady high with a full, stalled pipeline");
		end

endmodule

bind fpMultiplier fpMultiplier_props props_i (
	.clk(clk),
	.rstN(rstN),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.product(product),
	.slice1Valid(slice1Valid),
	.slice2Valid(slice2Valid)
);

/* testbench/fpMultChecker.sv */
`timescale 1ns/100ps

// Scoreboard for the multiplier output
// Results are matched to golden vectors in order
module fpMultChecker (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input logic [fpFormatPkg::wordWidth-1:0] product,
	input int vecCount,
	input logic endOfTest,
	output int errorCount,
	output int resultCount
);

	import fpFormatPkg::*;

	localparam int maxVectors = 64;
	localparam int expectedLatency = 3;		// Accept edge to output edge

	logic [3*wordWidth-1:0] golden [0:maxVectors-1];
	int cycle;
	int stallCycles;		// Edges with outReady low
	int results;
	int errors;
	logic endReported;
	int acceptCycle [$];
	int acceptStalls [$];

	initial begin
		$readmemh("testbench/fpMultGolden.hex", golden);
	end

	always @(posedge clk) begin : watch
		logic [wordWidth-1:0] expA;
		logic [wordWidth-1:0] expB;
		logic [wordWidth-1:0] expProd;
		int accCycle;
		int accStalls;
		if (!rstN) begin
			cycle = 0;
			stallCycles = 0;
			results = 0;
			errors = 0;
			endReported = 1'b0;
			acceptCycle.delete();
			acceptStalls.delete();
		end else begin
			cycle++;
			if (!outReady) stallCycles++;
			if (inValid && inReady) begin
				acceptCycle.push_back(cycle);	// Input taken on this edge
				acceptStalls.push_back(stallCycles);
			end
			if (outValid && outReady) begin
				if (results >= vecCount || acceptCycle.size() == 0) begin
					$display("Extra result %h at %0t ns with no input left to answer",
						product, $time);
					errors++;
				end else begin
					{expA, expB, expProd} = golden[results];
					accCycle = acceptCycle.pop_front();
					accStalls = acceptStalls.pop_front();
					if (product !== expProd) begin
						$display("FAILED at %0t ns: %h * %h expected %h got %h",
							$time, expA, expB, expProd, product);
						errors++;
					end
					// Latency only judged when no stall hit this item
					if (accStalls == stallCycles && cycle - accCycle != expectedLatency) begin
						$display("FAILED at %0t ns: %h * %h took %0d cycles, expected %0d",
							$time, expA, expB, cycle - accCycle, expectedLatency);
						errors++;
					end
					results++;
				end
			end
			if (endOfTest && !endReported) begin
				endReported = 1'b1;
				if (results < vecCount) begin
					$display("Only %0d of %0d results arrived by the end of the test",
						results, vecCount);
					errors++;
				end
			end
		end
		resultCount <= results;
		errorCount <= errors;
	end

endmodule

/* testbench/fpMultTb.sv */
`timescale 1ns/100ps

// Top-level testbench for the binary16 multiplier
module fpMultTb;

	localparam int maxVectors = 64;
	localparam logic [47:0] endMarker = 48'hFFFF_FFFF_FFFF;	// Closes the vector file

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	logic [15:0] a;
	logic [15:0] b;
	logic outValid;
	logic outReady;
	logic [15:0] product;
	logic endOfTest;

	logic [47:0] golden [0:maxVectors-1];
	int vecCount;
	int sent;			// Inputs accepted so far
	int cycleCount = 0;
	int timeoutLimit = 100;
	int seed;
	int errorCount;
	int resultCount;
	int assertFails;
	int setupErrors;
	int totalErrors;
	logic stallPhase;

	fpMultiplier fpMultiplier_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.a(a),
		.b(b),
		.outValid(outValid),
		.outReady(outReady),
		.product(product)
	);

	fpMultChecker checker_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.outValid(outValid),
		.outReady(outReady),
		.product(product),
		.vecCount(vecCount),
		.endOfTest(endOfTest),
		.errorCount(errorCount),
		.resultCount(resultCount)
	);

	always #10 clk = ~clk;		// 20 ns period

	// Watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout after %0d cycles with %0d of %0d results received",
				cycleCount, resultCount, vecCount);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rstN <= 1'b0;
		inValid <= 1'b0;
		a <= '0;
		b <= '0;
		outReady <= 1'b0;
		endOfTest <= 1'b0;
		seed = 64242;
		sent = 0;
		setupErrors = 0;
		$readmemh("testbench/fpMultGolden.hex", golden);
		vecCount = 0;
		while (vecCount < maxVectors && golden[vecCount] !== endMarker) vecCount++;
		if (vecCount == 0) begin
			$display("No test vectors found in the vector file");
			setupErrors = 1;
		end
		timeoutLimit = vecCount * 8 + 100;

		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		outReady <= 1'b1;

		// First half with outReady high, second half with stalls
		while (sent < vecCount) begin
			@(posedge clk);
			if (inValid && inReady) sent++;
			stallPhase = (sent >= vecCount / 2);
			if (!inValid || inReady) begin		// Held data waits for its transfer
				if (sent < vecCount && ($random(seed) & 3) != 0) begin
					inValid <= 1'b1;
					a <= golden[sent][47:32];
					b <= golden[sent][31:16];
				end else begin
					inValid <= 1'b0;	// Gap, or nothing left
				end
			end
			outReady <= stallPhase ? (($random(seed) & 7) < 3) : 1'b1;
		end

		// Drain under stalls, stops short of the cycle limit if results go missing
		while (resultCount < vecCount && cycleCount < timeoutLimit - 20) begin
			@(posedge clk);
			outReady <= ($random(seed) & 7) < 3;
		end
		outReady <= 1'b1;
		repeat (8) @(posedge clk);		// Room for stray extra results
		endOfTest <= 1'b1;
		repeat (2) @(posedge clk);

		assertFails = fpMultiplier_i.props_i.failCount;
		totalErrors = errorCount + assertFails + setupErrors;
		$display("Errors: %0d (checker %0d, assertions %0d, setup %0d)",
			totalErrors, errorCount, assertFails, setupErrors);
		if (totalErrors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* flist.f */
verilog/fpPipePkg.sv
verilog/fpFormatPkg.sv
verilog/fpPipeStage.sv
verilog/fpMultPrepare.sv
verilog/fpMultExecute.sv
verilog/fpMultRound.sv
verilog/fpMultiplier.sv
testbench/fpMultiplier_props.sv
testbench/fpMultChecker.sv
testbench/fpMultTb.sv

/* Makefile */
# Verilator flow for the binary16 multiplier
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= fpMultTb
FLIST ?= flist.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
SIMARGS ?= +verilator+error+limit+1000
FAILMSG ?= Simulation failed
PASSMSG ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o V$(TOP)
	-./$(OBJDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)

/* testbench/fpMultGolden.hex */
// Each word is a, b, expected product, 4 hex digits each (48 bits)
// Last word ffffffffffff marks the end
3c003c003c00
400042004600
420042004880
c0003e00c200
3c013c013c02
3c013e003e02
3c033e003e04
3e013e004081
3d563dff4000
bd563dffc000
7bff40007c00
7800f800fc00
040004000000
840004008000
20001c000000
3c0004000400
83ff40008000
7e003c007e00
7c0100007e00
7c0000007e00
7c00c000fc00
fc00fc007c00
0000c2008000
800080000000
ffffffffffff
